// ==== source/hdc_macros.svh ====
`ifndef HDC_MACROS_SVH
`define HDC_MACROS_SVH

// top bit index of one hypervector
`define HDC_DIM 63

// item memory geometry
`define HDC_ITEMS 1024
`define HDC_ADDR_W 10

// width of one bundler counter
`define HDC_CNT_W 8

// instruction field bits
`define HDC_OP_ADDR 15
`define HDC_OP_LOAD 14
`define HDC_OP_WBITEM 10

`endif

// ==== source/hdc_pkg.sv ====
`include "hdc_macros.svh"

package hdc_pkg;

    // one binary hypervector
    typedef logic [`HDC_DIM:0] hv_t;

    // item memory address
    typedef logic [`HDC_ADDR_W-1:0] item_addr_t;

    // one instruction word from the host
    typedef logic [15:0] inst_t;

    // configuration register bus
    typedef logic [2:0] cfg_addr_t;
    typedef logic [15:0] cfg_data_t;

    // random fill sequencer
    typedef enum logic {
        gen_idle,
        gen_sweep
    } gen_state_t;

endpackage

// ==== source/hdc_cfg_regs.sv ====
`timescale 1ns/100ps

module hdc_cfg_regs (
    input  logic               clk,
    input  logic               rst,
    input  logic               cfg_we,
    input  hdc_pkg::cfg_addr_t cfg_addr,
    input  hdc_pkg::cfg_data_t cfg_data,
    output logic               run,
    output hdc_pkg::hv_t       seed,
    output logic               seed_load,
    output logic               gen_step,
    output logic               gen_we,
    output hdc_pkg::item_addr_t gen_addr,
    output logic               gen_busy
);
    import hdc_pkg::*;

    logic [63:0] seed_q;
    gen_state_t  gen_state;
    cfg_data_t   gen_left;

    // a write to address 5 starts a fill sweep
    assign seed_load = cfg_we && (cfg_addr == 3'd5);
    assign seed      = hv_t'(seed_q);
    assign gen_step  = gen_we;
    assign gen_busy  = (gen_state == gen_sweep);

    always_ff @(posedge clk) begin
        if (rst) begin
            run <= 1'b0;
        end else if (cfg_we && (cfg_addr == 3'd0)) begin
            run <= cfg_data[0];
        end
    end

    // seed words, low word at address 1
    always_ff @(posedge clk) begin
        if (cfg_we) begin
            case (cfg_addr)
                3'd1: seed_q[15:0]  <= cfg_data;
                3'd2: seed_q[31:16] <= cfg_data;
                3'd3: seed_q[47:32] <= cfg_data;
                3'd4: seed_q[63:48] <= cfg_data;
                default: ;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            gen_state <= gen_idle;
            gen_we    <= 1'b0;
            gen_addr  <= '0;
            gen_left  <= '0;
        end else if (seed_load) begin
            gen_addr <= '0;
            gen_left <= cfg_data;
            // zero length means nothing to write
            if (cfg_data != '0) begin
                gen_state <= gen_sweep;
                gen_we    <= 1'b1;
            end else begin
                gen_state <= gen_idle;
                gen_we    <= 1'b0;
            end
        end else if (gen_state == gen_sweep) begin
            gen_addr <= gen_addr + 1'b1;
            gen_left <= gen_left - 1'b1;
            if (gen_left == 16'd1) begin
                gen_state <= gen_idle;
                gen_we    <= 1'b0;
            end
        end
    end

    a_gen_we_in_sweep: assert property (
        @(posedge clk) disable iff (rst) gen_we |-> (gen_state == gen_sweep)
    );

endmodule

// ==== source/hdc_hv_gen.sv ====
`timescale 1ns/100ps

module hdc_hv_gen (
    input  logic         clk,
    input  logic         rst,
    input  logic         seed_load,
    input  hdc_pkg::hv_t seed,
    input  logic         gen_step,
    output hdc_pkg::hv_t rand_hv
);
    import hdc_pkg::*;

    hv_t state;
    hv_t state_next;

    // xorshift, shifts of 13, 7 and 17
    always_comb begin
        state_next = state ^ (state << 13);
        state_next = state_next ^ (state_next >> 7);
        state_next = state_next ^ (state_next << 17);
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= '1;
        end else if (seed_load) begin
            // all zero would lock the generator
            state <= (seed == '0) ? '1 : seed;
        end else if (gen_step) begin
            state <= state_next;
        end
    end

    // current state is the vector written this cycle
    assign rand_hv = state;

endmodule

// ==== source/hdc_item_memory.sv ====
`timescale 1ns/100ps

`include "hdc_macros.svh"

module hdc_item_memory (
    input  logic                clk,
    input  logic                gen_we,
    input  hdc_pkg::item_addr_t gen_addr,
    input  hdc_pkg::hv_t        rand_hv,
    input  logic                wb_we,
    input  hdc_pkg::item_addr_t wb_addr,
    input  hdc_pkg::hv_t        wb_data,
    input  hdc_pkg::item_addr_t rd_addr,
    output hdc_pkg::hv_t        rd_data,
    output logic                fwd
);
    import hdc_pkg::*;

    hv_t mem [0:`HDC_ITEMS-1];

    // single write port, write-back ahead of the random fill
    always_ff @(posedge clk) begin
        if (wb_we) begin
            mem[wb_addr] <= wb_data;
        end else if (gen_we) begin
            mem[gen_addr] <= rand_hv;
        end
    end

    // read every cycle, old data on a same-address write
    always_ff @(posedge clk) begin
        rd_data <= mem[rd_addr];
    end

    // tells the core the read data is stale
    always_ff @(posedge clk) begin
        fwd <= wb_we && (wb_addr == rd_addr);
    end

    a_wb_wins: assert property (
        @(posedge clk) (wb_we && gen_we) |=> (mem[$past(wb_addr)] == $past(wb_data))
    );

endmodule

// ==== source/hdc_core.sv ====
`timescale 1ns/100ps

`include "hdc_macros.svh"

module hdc_core (
    input  logic                clk,
    input  logic                rst,
    input  logic                run,
    input  logic                get_v,
    input  hdc_pkg::inst_t      get_d,
    output hdc_pkg::item_addr_t rd_addr,
    input  hdc_pkg::hv_t        rd_data,
    input  logic                fwd,
    input  hdc_pkg::hv_t        sign_hv,
    output logic                wb_we,
    output hdc_pkg::item_addr_t wb_addr,
    output hdc_pkg::hv_t        wb_data,
    output logic                store,
    output hdc_pkg::hv_t        core_result,
    output logic                last
);
    import hdc_pkg::*;

    inst_t inst;
    logic  exec;
    logic  is_wbitem;
    hv_t   reg_1;
    hv_t   reg_2;
    hv_t   operand;

    // address field goes to memory straight away
    assign rd_addr   = get_d[`HDC_ADDR_W-1:0];
    assign is_wbitem = get_d[`HDC_OP_ADDR] && get_d[`HDC_OP_WBITEM];

    always_ff @(posedge clk) begin
        if (rst) begin
            exec  <= 1'b0;
            wb_we <= 1'b0;
            inst  <= '0;
        end else begin
            exec  <= get_v;
            wb_we <= get_v && is_wbitem;
            // wb.item runs as a nop in the exec stage
            inst  <= (get_v && !is_wbitem) ? get_d : '0;
        end
    end

    always_ff @(posedge clk) begin
        if (get_v) begin
            wb_addr <= get_d[`HDC_ADDR_W-1:0];
        end
    end

    assign wb_data = reg_2;

    // memory is one write late right after a wb.item
    assign operand = fwd ? reg_2 : rd_data;

    always_ff @(posedge clk) begin
        if (rst || !run) begin
            reg_1       <= '0;
            reg_2       <= '0;
            store       <= 1'b0;
            last        <= 1'b0;
            core_result <= '0;
        end else begin
            store       <= 1'b0;
            last        <= 1'b0;
            core_result <= '0;
            if (exec) begin
                if (inst[`HDC_OP_ADDR]) begin
                    // load, l.rshift, l.lshift, l.xor
                    if (inst[`HDC_OP_LOAD]) begin
                        reg_2 <= operand;
                    end else if (inst[13]) begin
                        reg_2 <= {operand[0], operand[`HDC_DIM:1]};
                    end else if (inst[12]) begin
                        reg_2 <= {operand[`HDC_DIM-1:0], operand[`HDC_DIM]};
                    end else if (inst[11]) begin
                        reg_2 <= operand ^ reg_2;
                    end
                end else if (inst[14]) begin
                    reg_2 <= {reg_2[0], reg_2[`HDC_DIM:1]};
                end else if (inst[13]) begin
                    reg_2 <= {reg_2[`HDC_DIM-1:0], reg_2[`HDC_DIM]};
                end else if (inst[12]) begin
                    reg_2 <= reg_1 ^ reg_2;
                end else if (inst[11]) begin
                    store       <= 1'b1;
                    core_result <= reg_2;
                end else if (inst[10]) begin
                    last <= 1'b1;
                end else if (inst[9]) begin
                    reg_1 <= reg_2;
                end else if (inst[8]) begin
                    // wb takes the bundled majority
                    reg_2 <= sign_hv;
                end
            end
        end
    end

    a_quiet_when_stopped: assert property (
        @(posedge clk) disable iff (rst) !run |=> (!store && !last)
    );

    a_result_only_on_store: assert property (
        @(posedge clk) disable iff (rst) !store |-> (core_result == '0)
    );

endmodule

// ==== source/hdc_bundler.sv ====
`timescale 1ns/100ps

`include "hdc_macros.svh"

module hdc_bundler (
    input  logic         clk,
    input  logic         rst,
    input  logic         run,
    input  logic         store,
    input  hdc_pkg::hv_t core_result,
    output hdc_pkg::hv_t sign_hv
);

    // two's complement limits of one counter
    localparam logic [`HDC_CNT_W-1:0] cnt_max = {1'b0, {(`HDC_CNT_W-1){1'b1}}};
    localparam logic [`HDC_CNT_W-1:0] cnt_min = {1'b1, {(`HDC_CNT_W-1){1'b0}}};

    logic [`HDC_CNT_W-1:0] cnt [0:`HDC_DIM];

    // one up/down counter per bit
    always_ff @(posedge clk) begin
        if (rst || !run) begin
            for (int i = 0; i <= `HDC_DIM; i++) begin
                cnt[i] <= '0;
            end
        end else if (store) begin
            for (int i = 0; i <= `HDC_DIM; i++) begin
                if (core_result[i]) begin
                    if (cnt[i] != cnt_max) begin
                        cnt[i] <= cnt[i] + 1'b1;
                    end
                end else begin
                    if (cnt[i] != cnt_min) begin
                        cnt[i] <= cnt[i] - 1'b1;
                    end
                end
            end
        end
    end

    // strictly positive gives a one, a tie gives zero
    always_comb begin
        for (int i = 0; i <= `HDC_DIM; i++) begin
            sign_hv[i] = !cnt[i][`HDC_CNT_W-1] && (cnt[i] != '0);
        end
    end

endmodule

// ==== source/hdc_top.sv ====
`timescale 1ns/100ps

module hdc_top (
    input  logic               clk,
    input  logic               rst,
    input  logic               cfg_we,
    input  hdc_pkg::cfg_addr_t cfg_addr,
    input  hdc_pkg::cfg_data_t cfg_data,
    input  logic               get_v,
    input  hdc_pkg::inst_t     get_d,
    output logic               store,
    output hdc_pkg::hv_t       core_result,
    output logic               last,
    output logic               gen_busy
);
    import hdc_pkg::*;

    logic       run;
    hv_t        seed;
    logic       seed_load;
    logic       gen_step;
    logic       gen_we;
    item_addr_t gen_addr;
    hv_t        rand_hv;
    item_addr_t rd_addr;
    hv_t        rd_data;
    logic       fwd;
    logic       wb_we;
    item_addr_t wb_addr;
    hv_t        wb_data;
    hv_t        sign_hv;

    hdc_cfg_regs u_cfg_regs (
        .clk       (clk),
        .rst       (rst),
        .cfg_we    (cfg_we),
        .cfg_addr  (cfg_addr),
        .cfg_data  (cfg_data),
        .run       (run),
        .seed      (seed),
        .seed_load (seed_load),
        .gen_step  (gen_step),
        .gen_we    (gen_we),
        .gen_addr  (gen_addr),
        .gen_busy  (gen_busy)
    );

    hdc_hv_gen u_hv_gen (
        .clk       (clk),
        .rst       (rst),
        .seed_load (seed_load),
        .seed      (seed),
        .gen_step  (gen_step),
        .rand_hv   (rand_hv)
    );

    hdc_item_memory u_item_memory (
        .clk      (clk),
        .gen_we   (gen_we),
        .gen_addr (gen_addr),
        .rand_hv  (rand_hv),
        .wb_we    (wb_we),
        .wb_addr  (wb_addr),
        .wb_data  (wb_data),
        .rd_addr  (rd_addr),
        .rd_data  (rd_data),
        .fwd      (fwd)
    );

    hdc_core u_core (
        .clk         (clk),
        .rst         (rst),
        .run         (run),
        .get_v       (get_v),
        .get_d       (get_d),
        .rd_addr     (rd_addr),
        .rd_data     (rd_data),
        .fwd         (fwd),
        .sign_hv     (sign_hv),
        .wb_we       (wb_we),
        .wb_addr     (wb_addr),
        .wb_data     (wb_data),
        .store       (store),
        .core_result (core_result),
        .last        (last)
    );

    hdc_bundler u_bundler (
        .clk         (clk),
        .rst         (rst),
        .run         (run),
        .store       (store),
        .core_result (core_result),
        .sign_hv     (sign_hv)
    );

endmodule

// ==== sim/hdc_checker.sv ====
`timescale 1ns/100ps

`include "hdc_macros.svh"

module hdc_checker (
    input  logic               clk,
    input  logic               rst,
    input  logic               cfg_we,
    input  hdc_pkg::cfg_addr_t cfg_addr,
    input  hdc_pkg::cfg_data_t cfg_data,
    input  logic               get_v,
    input  hdc_pkg::inst_t     get_d,
    input  logic               store,
    input  hdc_pkg::hv_t       core_result,
    input  logic               last,
    input  logic               gen_busy,
    output int                 errors,
    output int                 checks
);
    import hdc_pkg::*;

    // saturation limits of one bundle counter
    localparam int cnt_hi = (1 << (`HDC_CNT_W - 1)) - 1;
    localparam int cnt_lo = -(1 << (`HDC_CNT_W - 1));

    hv_t         mem_m [0:`HDC_ITEMS-1];
    int          cnt_m [0:`HDC_DIM];
    hv_t         reg_1_m;
    hv_t         reg_2_m;
    hv_t         gen_m;
    logic [63:0] seed_m;
    int          gen_left;
    item_addr_t  gen_addr_m;
    logic        run_m;
    logic        pend_v;
    inst_t       pend_inst;
    logic        exp_store;
    logic        exp_last;
    hv_t         exp_result;
    logic        ready = 1'b0;
    int          err_cnt = 0;
    int          chk_cnt = 0;

    assign errors = err_cnt;
    assign checks = chk_cnt;

    function automatic hv_t xorshift_step(hv_t s);
        logic [63:0] x;
        x = 64'(s);
        x = x ^ (x << 13);
        x = x ^ (x >> 7);
        x = x ^ (x << 17);
        return hv_t'(x);
    endfunction

    function automatic hv_t rotate_right(hv_t x);
        return (x >> 1) | (x << `HDC_DIM);
    endfunction

    function automatic hv_t rotate_left(hv_t x);
        return (x << 1) | (x >> `HDC_DIM);
    endfunction

    // positive count gives a one, a tie stays zero
    function automatic hv_t majority_vector();
        hv_t v;
        for (int i = 0; i <= `HDC_DIM; i++) begin
            v[i] = (cnt_m[i] > 0);
        end
        return v;
    endfunction

    task automatic clear_counters();
        for (int i = 0; i <= `HDC_DIM; i++) begin
            cnt_m[i] = 0;
        end
    endtask

    task automatic bundle_vector(hv_t v);
        for (int i = 0; i <= `HDC_DIM; i++) begin
            if (v[i] && (cnt_m[i] < cnt_hi)) begin
                cnt_m[i]++;
            end else if (!v[i] && (cnt_m[i] > cnt_lo)) begin
                cnt_m[i]--;
            end
        end
    endtask

    task automatic execute(inst_t op, hv_t sign_v);
        hv_t m;
        m = mem_m[op[`HDC_ADDR_W-1:0]];
        if (op[15]) begin
            case (op[14:10])
                5'b10000: reg_2_m = m;
                5'b01000: reg_2_m = rotate_right(m);
                5'b00100: reg_2_m = rotate_left(m);
                5'b00010: reg_2_m = m ^ reg_2_m;
                default: ;
            endcase
        end else begin
            case (op[14:8])
                7'h40: reg_2_m = rotate_right(reg_2_m);
                7'h20: reg_2_m = rotate_left(reg_2_m);
                7'h10: reg_2_m = reg_1_m ^ reg_2_m;
                7'h08: begin
                    exp_store  = 1'b1;
                    exp_result = reg_2_m;
                end
                7'h04: exp_last = 1'b1;
                7'h02: reg_1_m = reg_2_m;
                7'h01: reg_2_m = sign_v;
                default: ;
            endcase
        end
    endtask

    task automatic compare_value(string what, hv_t got, hv_t exp);
        if (got !== exp) begin
            err_cnt++;
            $display("Error at %0t ns: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    // model state after each rising edge
    always @(posedge clk) begin
        hv_t  sign_v;
        logic wb_hit;
        if (rst) begin
            run_m      = 1'b0;
            pend_v     = 1'b0;
            gen_left   = 0;
            reg_1_m    = '0;
            reg_2_m    = '0;
            exp_store  = 1'b0;
            exp_last   = 1'b0;
            exp_result = '0;
            clear_counters();
        end else begin
            sign_v = majority_vector();
            if (!run_m) begin
                clear_counters();
            end else if (exp_store) begin
                bundle_vector(exp_result);
            end
            exp_store  = 1'b0;
            exp_last   = 1'b0;
            exp_result = '0;
            // wb.item lands one cycle after issue
            wb_hit = pend_v && pend_inst[15] && (pend_inst[14:10] == 5'b00001);
            // one fill write per sweep cycle, lost under a write-back
            if (gen_left > 0) begin
                if (!wb_hit) begin
                    mem_m[gen_addr_m] = gen_m;
                end
                gen_m = xorshift_step(gen_m);
                gen_addr_m = gen_addr_m + 1'b1;
                gen_left--;
            end
            if (wb_hit) begin
                mem_m[pend_inst[`HDC_ADDR_W-1:0]] = reg_2_m;
            end
            if (!run_m) begin
                reg_1_m = '0;
                reg_2_m = '0;
            end else if (pend_v) begin
                execute(pend_inst, sign_v);
            end
            pend_v    = get_v;
            pend_inst = get_d;
            if (cfg_we) begin
                case (cfg_addr)
                    3'd0: run_m = cfg_data[0];
                    3'd1: seed_m[15:0] = cfg_data;
                    3'd2: seed_m[31:16] = cfg_data;
                    3'd3: seed_m[47:32] = cfg_data;
                    3'd4: seed_m[63:48] = cfg_data;
                    3'd5: begin
                        gen_m      = (seed_m == '0) ? '1 : hv_t'(seed_m);
                        gen_addr_m = '0;
                        gen_left   = int'(cfg_data);
                    end
                    default: ;
                endcase
            end
        end
        ready = !rst;
    end

    // outputs are settled by the falling edge
    always @(negedge clk) begin
        if (ready) begin
            chk_cnt++;
            compare_value("store", hv_t'(store), hv_t'(exp_store));
            compare_value("core_result", core_result, exp_result);
            compare_value("last", hv_t'(last), hv_t'(exp_last));
            compare_value("gen_busy", hv_t'(gen_busy), hv_t'(gen_left > 0));
        end
    end

endmodule

// ==== sim/hdc_tb.sv ====
`timescale 1ns/100ps

module hdc_tb;
    import hdc_pkg::*;

    localparam int kind_cfg  = 0;
    localparam int kind_inst = 1;
    localparam int kind_idle = 2;
    localparam int kind_wait = 3;
    localparam int sweep_len = 16;

    // opcodes, item address in bits 9 to 0
    localparam inst_t op_load   = 16'hc000;
    localparam inst_t op_lrot_r = 16'ha000;
    localparam inst_t op_lrot_l = 16'h9000;
    localparam inst_t op_lxor   = 16'h8800;
    localparam inst_t op_wbitem = 16'h8400;
    localparam inst_t op_rot_r  = 16'h4000;
    localparam inst_t op_rot_l  = 16'h2000;
    localparam inst_t op_xor    = 16'h1000;
    localparam inst_t op_store  = 16'h0800;
    localparam inst_t op_last   = 16'h0400;
    localparam inst_t op_move   = 16'h0200;
    localparam inst_t op_wb     = 16'h0100;

    logic      clk = 1'b0;
    logic      rst;
    logic      cfg_we;
    cfg_addr_t cfg_addr;
    cfg_data_t cfg_data;
    logic      get_v;
    inst_t     get_d;
    logic      store;
    hv_t       core_result;
    logic      last;
    logic      gen_busy;
    int        errors;
    int        checks;
    int        limit = 0;
    int        cycles = 0;
    inst_t     k [0:3];
    inst_t     wb_a;

    // stimulus table
    int        kind_q[$];
    cfg_addr_t addr_q[$];
    cfg_data_t data_q[$];

    always #5 clk = ~clk;

    hdc_top DUT (
        .clk         (clk),
        .rst         (rst),
        .cfg_we      (cfg_we),
        .cfg_addr    (cfg_addr),
        .cfg_data    (cfg_data),
        .get_v       (get_v),
        .get_d       (get_d),
        .store       (store),
        .core_result (core_result),
        .last        (last),
        .gen_busy    (gen_busy)
    );

    hdc_checker u_checker (
        .clk         (clk),
        .rst         (rst),
        .cfg_we      (cfg_we),
        .cfg_addr    (cfg_addr),
        .cfg_data    (cfg_data),
        .get_v       (get_v),
        .get_d       (get_d),
        .store       (store),
        .core_result (core_result),
        .last        (last),
        .gen_busy    (gen_busy),
        .errors      (errors),
        .checks      (checks)
    );

    task automatic add_cfg(cfg_addr_t a, cfg_data_t d);
        kind_q.push_back(kind_cfg);
        addr_q.push_back(a);
        data_q.push_back(d);
    endtask

    task automatic add_inst(inst_t d);
        kind_q.push_back(kind_inst);
        addr_q.push_back('0);
        data_q.push_back(d);
    endtask

    task automatic add_step(int kind);
        kind_q.push_back(kind);
        addr_q.push_back('0);
        data_q.push_back('0);
    endtask

    task automatic build_table();
        // seed words, then a fill sweep
        add_cfg(3'd1, 16'h1234);
        add_cfg(3'd2, 16'h5678);
        add_cfg(3'd3, 16'h9abc);
        add_cfg(3'd4, 16'hdef0);
        add_cfg(3'd5, cfg_data_t'(sweep_len));
        add_step(kind_wait);
        add_cfg(3'd0, 16'h0001);
        // loads with rotate and xor
        add_inst(op_load | k[0]);
        add_inst(op_store);
        add_inst(op_lrot_r | k[1]);
        add_inst(op_store);
        add_inst(op_lrot_l | k[2]);
        add_inst(op_store);
        add_inst(op_load | k[0]);
        add_inst(op_lxor | k[3]);
        add_inst(op_store);
        // register ops back to back
        add_inst(op_move);
        add_inst(op_load | k[1]);
        add_inst(op_rot_r);
        add_inst(op_rot_l);
        add_inst(op_rot_l);
        add_inst(op_xor);
        add_inst(op_store);
        add_inst(op_move);
        add_inst(op_rot_r);
        add_inst(op_store);
        // write-back, then reload at once and later
        add_inst(op_wbitem | wb_a);
        add_inst(op_load | wb_a);
        add_inst(op_store);
        add_inst(op_load | k[2]);
        add_inst(op_store);
        add_inst(op_load | wb_a);
        add_inst(op_store);
        // fresh bundle of three vectors
        add_cfg(3'd0, 16'h0000);
        add_cfg(3'd0, 16'h0001);
        add_inst(op_load | k[0]);
        add_inst(op_store);
        add_inst(op_lrot_r | k[1]);
        add_inst(op_store);
        add_inst(op_load | k[2]);
        add_inst(op_store);
        add_step(kind_idle);
        add_inst(op_wb);
        add_inst(op_store);
        // last, then a stop clears reg_2
        add_inst(op_last);
        add_inst(op_load | k[3]);
        add_cfg(3'd0, 16'h0000);
        add_cfg(3'd0, 16'h0001);
        add_inst(op_store);
        add_step(kind_idle);
    endtask

    task automatic drive_idle();
        cfg_we   = 1'b0;
        cfg_addr = '0;
        cfg_data = '0;
        get_v    = 1'b0;
        get_d    = '0;
    endtask

    task automatic apply_entry(int i);
        @(negedge clk);
        drive_idle();
        case (kind_q[i])
            kind_cfg: begin
                cfg_we   = 1'b1;
                cfg_addr = addr_q[i];
                cfg_data = data_q[i];
            end
            kind_inst: begin
                get_v = 1'b1;
                get_d = data_q[i];
            end
            kind_wait: begin
                // fill is done once gen_busy drops
                while (gen_busy) begin
                    @(negedge clk);
                end
            end
            default: ;
        endcase
    endtask

    always @(posedge clk) begin
        cycles++;
        if ((limit > 0) && (cycles > limit)) begin
            $display("Timeout: the test table did not finish within %0d cycles", limit);
            $display("Regression failed");
            $finish;
        end
    end

    initial begin
        rst = 1'b1;
        drive_idle();
        void'($urandom(97916));
        for (int i = 0; i < 4; i++) begin
            k[i] = inst_t'($urandom % sweep_len);
        end
        // write-back target outside the filled range
        wb_a = inst_t'(sweep_len + ($urandom % 1000));
        build_table();
        limit = kind_q.size() * 4 + sweep_len + 100;
        repeat (2) @(negedge clk);
        rst = 1'b0;
        for (int i = 0; i < kind_q.size(); i++) begin
            apply_entry(i);
        end
        @(negedge clk);
        drive_idle();
        // two cycles of pipeline plus margin
        repeat (4) @(negedge clk);
        $display("checks: %0d, errors: %0d", checks, errors);
        if ((errors == 0) && (checks > 0)) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

// ==== hdc_accel.f ====
+incdir+source
source/hdc_pkg.sv
source/hdc_cfg_regs.sv
source/hdc_hv_gen.sv
source/hdc_item_memory.sv
source/hdc_core.sv
source/hdc_bundler.sv
source/hdc_top.sv
sim/hdc_checker.sv
sim/hdc_tb.sv

// ==== Makefile ====
# Verilator build and run for the hdc_accel testbench

VERILATOR ?= verilator
TOP       ?= hdc_tb
FILELIST  ?= hdc_accel.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --assert --timing
PASS_MSG  ?= Regression passed

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

build:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)

# the log decides, so a failed run leaves a non-zero status
sim: build
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "^$(PASS_MSG)$$" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
